// File: verilog/pio_mem_cfg.svh
/*
 * bus width, region decode and table shapes for the PIO lookup tables.
 * regions are decoded from address bits 11:10 only, so each region spans 1 KiB.
 */

`ifndef PIO_MEM_CFG_SVH
`define PIO_MEM_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~ PIO bus ~~~~~~~~~~~~~~~~~~~~
`define PIO_NBITS 32 // data and address width of the host bus.

// the region select field inside a PIO byte address.
`define TBL_SEL_MSB 11
`define TBL_SEL_LSB 10

// byte base addresses of the two regions. only the select field is compared.
`define TBL_A_BASE 32'h0000_0000
`define TBL_B_BASE 32'h0000_0400

// ~~~~~~~~~~~~~~~~~~~~ table shapes ~~~~~~~~~~~~~~~~~~~~
`define TBL_A_WIDTH 20      // table a entry width.
`define TBL_A_DEPTH_NBITS 8 // table a holds 256 entries.

`define TBL_B_WIDTH 12      // table b entry width.
`define TBL_B_DEPTH_NBITS 6 // table b holds 64 entries.

`endif

// File: verilog/pio_mem_pkg.sv
/*
 * shared types for the PIO lookup tables.
 * pio_req_t is a held level, so rd or wr stays high until the host sees ack.
 */

`include "pio_mem_cfg.svh"

package pio_mem_pkg;

	// ~~~~~~~~~~~~~~~~~~~~ words ~~~~~~~~~~~~~~~~~~~~
	typedef logic [`PIO_NBITS-1:0] pio_word_t; // one host data or address word.

	typedef logic [`TBL_A_WIDTH-1:0] tbl_a_word_t;       // one table a entry.
	typedef logic [`TBL_B_WIDTH-1:0] tbl_b_word_t;       // one table b entry.
	typedef logic [`TBL_A_DEPTH_NBITS-1:0] tbl_a_addr_t; // table a entry index.
	typedef logic [`TBL_B_DEPTH_NBITS-1:0] tbl_b_addr_t; // table b entry index.

	// ~~~~~~~~~~~~~~~~~~~~ host bus ~~~~~~~~~~~~~~~~~~~~
	// request from the host, held until acknowledged.
	typedef struct packed {
		pio_word_t addr;  // byte address, word aligned.
		pio_word_t wdata; // write data, only the low table width bits are kept.
		logic      rd;    // read request level.
		logic      wr;    // write request level.
	} pio_req_t;

	// response back to the host.
	typedef struct packed {
		logic      ack;   // changes only on a clk_div strobe.
		pio_word_t rdata; // zero extended table entry.
	} pio_rsp_t;

endpackage

// File: verilog/ram_1r1w.sv
/*
 * dual port RAM with one write port and one read port, registered read.
 * a read and a write to the same entry in one cycle return the old data.
 */

`timescale 1ns/1ns

module ram_1r1w #(
	parameter int WIDTH       = 20,
	parameter int DEPTH_NBITS = 8
) (
	input  logic                   clk,
	input  logic                   wr,    // write strobe.
	input  logic [DEPTH_NBITS-1:0] raddr, // read entry index.
	input  logic [DEPTH_NBITS-1:0] waddr, // write entry index.
	input  logic [WIDTH-1:0]       din,   // write data.
	output logic [WIDTH-1:0]       dout   // read data, one cycle after raddr.
);

	// the storage array. it has no reset and powers up undefined.
	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	// ~~~~~~~~~~~~~~~~~~~~ ports ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din; // takes effect at this edge.
		end
	end

	// the read samples the array before this edge's write lands.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

// File: verilog/pio_rw_mem.sv
/*
 * one lookup table shared by the application datapath and the host PIO bus.
 * the application side always wins; a colliding host access waits for a free cycle.
 */

`timescale 1ns/1ns

module pio_rw_mem import pio_mem_pkg::*; #(
	parameter int WIDTH       = 20,
	parameter int DEPTH_NBITS = 8,
	parameter bit REG_WR_EN   = 1'b1
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   clk_div,   // slow strobe that paces the host ack.
	input  pio_req_t               pio_req,   // held host request.
	input  logic                   reg_ms,    // this table is selected by the address.
	input  logic                   app_rd,
	input  logic [DEPTH_NBITS-1:0] app_raddr,
	input  logic                   app_wr,
	input  logic [DEPTH_NBITS-1:0] app_waddr,
	input  logic [WIDTH-1:0]       app_wdata,
	output pio_rsp_t               pio_rsp,
	output logic                   app_ack,   // one cycle pulse, three edges after app_rd.
	output logic [WIDTH-1:0]       app_rdata
);

	// ~~~~~~~~~~~~~~~~~~~~ stage one ~~~~~~~~~~~~~~~~~~~~
	// both sides are delayed one stage so they meet the RAM together.
	logic                   app_rd_d1;
	logic                   app_rd_d2;
	logic                   app_wr_d1;
	logic [DEPTH_NBITS-1:0] app_raddr_d1;
	logic [DEPTH_NBITS-1:0] app_waddr_d1;
	logic [WIDTH-1:0]       app_wdata_d1;

	logic                   stg_rd;    // host read for this table, stage one.
	logic                   stg_wr;    // host write for this table, stage one.
	pio_word_t              stg_addr;
	pio_word_t              stg_wdata;

	// host access bookkeeping.
	logic                   pio_done;  // the held request has been carried out.
	logic                   rd_save;   // host read lost a cycle to the application.
	logic                   wr_save;   // host write lost a cycle to the application.
	logic                   rd_go_d1;  // RAM output holds host read data.
	logic                   pio_pend;  // completion waits for a clk_div strobe.
	logic                   pio_ack;
	pio_word_t              pio_rdata;

	// RAM side.
	logic                   pio_rd_lvl;
	logic                   pio_wr_lvl;
	logic                   rd_go;
	logic                   wr_go;
	logic [DEPTH_NBITS-1:0] pio_idx;
	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [DEPTH_NBITS-1:0] ram_waddr;
	logic [WIDTH-1:0]       ram_wdata;
	logic [WIDTH-1:0]       ram_rdata;
	logic                   ram_wr;

	// payload registers carry no reset. only the strobes that qualify them do.
	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_raddr;
		app_waddr_d1 <= app_waddr;
		app_wdata_d1 <= app_wdata;
		stg_addr     <= pio_req.addr;
		stg_wdata    <= pio_req.wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_wr_d1 <= 1'b0;
			stg_rd    <= 1'b0;
			stg_wr    <= 1'b0;
		end else begin
			app_rd_d1 <= app_rd;
			app_rd_d2 <= app_rd_d1;
			app_wr_d1 <= app_wr;
			stg_rd    <= reg_ms & pio_req.rd; // only requests aimed at this table.
			stg_wr    <= reg_ms & pio_req.wr;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ arbitration ~~~~~~~~~~~~~~~~~~~~
	// the host request stays high for many cycles, so it is taken only once.
	assign pio_rd_lvl = stg_rd & ~pio_done;
	assign pio_wr_lvl = stg_wr & ~pio_done;

	// a host access goes on the first cycle its RAM port is free.
	assign rd_go = ~app_rd_d1 & (pio_rd_lvl | rd_save);
	assign wr_go = ~app_wr_d1 & (pio_wr_lvl | wr_save);

	assign pio_idx = stg_addr[DEPTH_NBITS+1:2]; // byte address to entry index.

	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : pio_idx;
	assign ram_waddr = app_wr_d1 ? app_waddr_d1 : pio_idx;
	assign ram_wdata = app_wr_d1 ? app_wdata_d1 : stg_wdata[WIDTH-1:0];

	// a read only table still completes the host write, it just never reaches the RAM.
	assign ram_wr = app_wr_d1 | (REG_WR_EN & wr_go);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_save  <= 1'b0;
			wr_save  <= 1'b0;
			pio_done <= 1'b0;
			rd_go_d1 <= 1'b0;
		end else begin
			if (app_rd_d1 & pio_rd_lvl) begin
				rd_save <= 1'b1; // the application owns the read port this cycle.
			end else if (rd_go) begin
				rd_save <= 1'b0;
			end
			if (app_wr_d1 & pio_wr_lvl) begin
				wr_save <= 1'b1;
			end else if (wr_go) begin
				wr_save <= 1'b0;
			end
			// done clears once the host has dropped its request.
			if (rd_go | wr_go) begin
				pio_done <= 1'b1;
			end else if (~(stg_rd | stg_wr)) begin
				pio_done <= 1'b0;
			end
			rd_go_d1 <= rd_go;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ host response ~~~~~~~~~~~~~~~~~~~~
	// a write completes when it is issued, a read when its data is captured.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pio_pend <= 1'b0;
			pio_ack  <= 1'b0;
		end else begin
			if (wr_go | rd_go_d1) begin
				pio_pend <= 1'b1;
			end else if (~(stg_rd | stg_wr)) begin
				pio_pend <= 1'b0;
			end
			if (clk_div) begin
				pio_ack <= pio_pend; // rises and falls only on the slow strobe.
			end
		end
	end

	// host read data is held until the next host read.
	always_ff @(posedge clk) begin
		if (rd_go_d1) begin
			pio_rdata <= {{($bits(pio_word_t) - WIDTH){1'b0}}, ram_rdata};
		end
	end

	assign pio_rsp = '{ack: pio_ack, rdata: pio_rdata};

	// ~~~~~~~~~~~~~~~~~~~~ application response ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		app_rdata <= ram_rdata; // valid in the cycle that app_ack is high.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			app_ack <= 1'b0;
		end else begin
			app_ack <= app_rd_d2;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ storage ~~~~~~~~~~~~~~~~~~~~
	ram_1r1w #(
		.WIDTH       (WIDTH),
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_ram (
		.clk   (clk),
		.wr    (ram_wr),
		.raddr (ram_raddr),
		.waddr (ram_waddr),
		.din   (ram_wdata),
		.dout  (ram_rdata)
	);

endmodule

// File: verilog/pio_resp_merge.sv
/*
 * decodes the table region from address bits 11:10 and merges the table responses.
 * region values 2 and 3 are unmapped; they ack with zero data and drop writes.
 */

`timescale 1ns/1ns

`include "pio_mem_cfg.svh"

module pio_resp_merge import pio_mem_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     clk_div, // slow strobe that paces the host ack.
	input  pio_req_t pio_req, // held host request.
	output logic     ms_a,    // address falls in table a.
	output logic     ms_b,    // address falls in table b.
	input  pio_rsp_t rsp_a,
	input  pio_rsp_t rsp_b,
	output pio_rsp_t pio_rsp
);

	// region codes taken from the base addresses.
	localparam pio_word_t base_a = `TBL_A_BASE;
	localparam pio_word_t base_b = `TBL_B_BASE;

	logic [`TBL_SEL_MSB-`TBL_SEL_LSB:0] sel;
	logic                               unm_req; // live request to no table.
	logic                               unm_pend;
	logic                               unm_ack;

	// ~~~~~~~~~~~~~~~~~~~~ decode ~~~~~~~~~~~~~~~~~~~~
	assign sel  = pio_req.addr[`TBL_SEL_MSB:`TBL_SEL_LSB];
	assign ms_a = (sel == base_a[`TBL_SEL_MSB:`TBL_SEL_LSB]);
	assign ms_b = (sel == base_b[`TBL_SEL_MSB:`TBL_SEL_LSB]);

	assign unm_req = ~ms_a & ~ms_b & (pio_req.rd | pio_req.wr);

	// ~~~~~~~~~~~~~~~~~~~~ unmapped ack ~~~~~~~~~~~~~~~~~~~~
	// one stage holds the request, the ack then follows it on clk_div
	// just as the tables do.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unm_pend <= 1'b0;
			unm_ack  <= 1'b0;
		end else begin
			unm_pend <= unm_req;
			if (clk_div) begin
				unm_ack <= unm_pend; // falls on the strobe after the request drops.
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ steering ~~~~~~~~~~~~~~~~~~~~
	// only the selected source can be acking, since the host keeps one request
	// outstanding. its ack therefore picks the data, and it stays correct
	// after the host has moved the address on.
	always_comb begin
		pio_rsp.ack = rsp_a.ack | rsp_b.ack | unm_ack;
		if (rsp_a.ack) begin
			pio_rsp.rdata = rsp_a.rdata;
		end else if (rsp_b.ack) begin
			pio_rsp.rdata = rsp_b.rdata;
		end else begin
			pio_rsp.rdata = '0; // unmapped reads return zero.
		end
	end

endmodule

// File: verilog/pio_mem_top.sv
/*
 * two PIO lookup tables and their response merger.
 * table a is host read and write; table b is host read only and filled by the application.
 */

`timescale 1ns/1ns

`include "pio_mem_cfg.svh"

module pio_mem_top import pio_mem_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        clk_div, // one cycle strobe that paces host acks.
	input  pio_req_t    pio_req,
	output pio_rsp_t    pio_rsp,

	// table a application port.
	input  logic        a_rd,
	input  tbl_a_addr_t a_raddr,
	input  logic        a_wr,
	input  tbl_a_addr_t a_waddr,
	input  tbl_a_word_t a_wdata,
	output logic        a_ack,
	output tbl_a_word_t a_rdata,

	// table b application port.
	input  logic        b_rd,
	input  tbl_b_addr_t b_raddr,
	input  logic        b_wr,
	input  tbl_b_addr_t b_waddr,
	input  tbl_b_word_t b_wdata,
	output logic        b_ack,
	output tbl_b_word_t b_rdata
);

	logic     ms_a;  // host address selects table a.
	logic     ms_b;  // host address selects table b.
	pio_rsp_t rsp_a;
	pio_rsp_t rsp_b;

	// ~~~~~~~~~~~~~~~~~~~~ tables ~~~~~~~~~~~~~~~~~~~~
	pio_rw_mem #(
		.WIDTH       (`TBL_A_WIDTH),
		.DEPTH_NBITS (`TBL_A_DEPTH_NBITS),
		.REG_WR_EN   (1'b1)
	) u_tbl_a (
		.clk       (clk),
		.rst_n     (rst_n),
		.clk_div   (clk_div),
		.pio_req   (pio_req),
		.reg_ms    (ms_a),
		.app_rd    (a_rd),
		.app_raddr (a_raddr),
		.app_wr    (a_wr),
		.app_waddr (a_waddr),
		.app_wdata (a_wdata),
		.pio_rsp   (rsp_a),
		.app_ack   (a_ack),
		.app_rdata (a_rdata)
	);

	// host writes to table b are acked but never reach its RAM.
	pio_rw_mem #(
		.WIDTH       (`TBL_B_WIDTH),
		.DEPTH_NBITS (`TBL_B_DEPTH_NBITS),
		.REG_WR_EN   (1'b0)
	) u_tbl_b (
		.clk       (clk),
		.rst_n     (rst_n),
		.clk_div   (clk_div),
		.pio_req   (pio_req),
		.reg_ms    (ms_b),
		.app_rd    (b_rd),
		.app_raddr (b_raddr),
		.app_wr    (b_wr),
		.app_waddr (b_waddr),
		.app_wdata (b_wdata),
		.pio_rsp   (rsp_b),
		.app_ack   (b_ack),
		.app_rdata (b_rdata)
	);

	// ~~~~~~~~~~~~~~~~~~~~ host response ~~~~~~~~~~~~~~~~~~~~
	pio_resp_merge u_merge (
		.clk     (clk),
		.rst_n   (rst_n),
		.clk_div (clk_div),
		.pio_req (pio_req),
		.ms_a    (ms_a),
		.ms_b    (ms_b),
		.rsp_a   (rsp_a),
		.rsp_b   (rsp_b),
		.pio_rsp (pio_rsp)
	);

endmodule

// File: tb/pio_mem_tb.sv
/*
 * testbench for the PIO lookup tables, stimulus and expected values from tb/pio_mem_stim.txt.
 * random filler writes use table a entries 0x80 and up and table b entries 0x20 and up.
 */

`timescale 1ns/1ns

module pio_mem_tb import pio_mem_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 10;
	localparam int MAX_OPS    = 64;
	localparam int ACK_WAIT   = 32; // cycles a host ack may take to rise or to fall.

	logic        clk;
	logic        rst_n;
	logic        clk_div;
	pio_req_t    pio_req;
	pio_rsp_t    pio_rsp;
	logic        a_rd;
	tbl_a_addr_t a_raddr;
	logic        a_wr;
	tbl_a_addr_t a_waddr;
	tbl_a_word_t a_wdata;
	logic        a_ack;
	tbl_a_word_t a_rdata;
	logic        b_rd;
	tbl_b_addr_t b_raddr;
	logic        b_wr;
	tbl_b_addr_t b_waddr;
	tbl_b_word_t b_wdata;
	logic        b_ack;
	tbl_b_word_t b_rdata;

	// one entry per operation line of the stim file.
	logic [7:0] st_port [MAX_OPS]; // A, B, P or C.
	logic       st_wr   [MAX_OPS];
	pio_word_t  st_addr [MAX_OPS];
	pio_word_t  st_data [MAX_OPS];
	pio_word_t  st_exp  [MAX_OPS];
	int         n_ops     = 0;
	logic       loaded    = 1'b0;
	int         err_data  = 0;
	int         err_proto = 0;
	int         seed;
	logic       div_seen  = 1'b0; // clk_div as the DUT saw it on the last rising edge.
	logic       ack_last  = 1'b0;

	pio_mem_top uut (.*);

	// ~~~~~~~~~~~~~~~~~~~~ clock and strobe ~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// clk_div is high one cycle in four and changes on the falling edge.
	initial begin
		logic [1:0] div_cnt;
		div_cnt = 2'd0;
		clk_div = 1'b0;
		forever begin
			@(negedge clk);
			div_cnt = div_cnt + 2'd1;
			clk_div = (div_cnt == 2'd3);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ checks ~~~~~~~~~~~~~~~~~~~~
	task automatic check_pio(input string name, input pio_word_t got, input pio_word_t exp);
		if (got !== exp) begin
			err_data = err_data + 1;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_a(input string name, input tbl_a_word_t got, input tbl_a_word_t exp);
		if (got !== exp) begin
			err_data = err_data + 1;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_b(input string name, input tbl_b_word_t got, input tbl_b_word_t exp);
		if (got !== exp) begin
			err_data = err_data + 1;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// the host ack may only move on an edge where clk_div was high.
	initial begin
		forever begin
			@(posedge clk);
			div_seen <= clk_div;
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (rst_n && pio_rsp.ack !== ack_last) begin
				if (!div_seen) begin
					err_proto = err_proto + 1;
					$display("host ack changed at %0t ns on an edge without clk_div", $time);
				end
				ack_last = pio_rsp.ack;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ stimulus ~~~~~~~~~~~~~~~~~~~~
	task automatic load_stim();
		int                 fd;
		int                 code;
		logic [7:0]         tok;
		logic [15:0]        op_tok;
		logic [8*120-1:0]   rest;
		pio_word_t          f_addr;
		pio_word_t          f_data;
		pio_word_t          f_exp;
		fd = $fopen("tb/pio_mem_stim.txt", "r");
		if (fd == 0) begin
			err_proto = err_proto + 1;
			$display("cannot open tb/pio_mem_stim.txt, no operations were run");
		end else begin
			code = $fscanf(fd, "%s", tok);
			while (code == 1) begin
				if (tok == "A" || tok == "B" || tok == "P" || tok == "C") begin
					code = $fscanf(fd, "%s %h %h %h", op_tok, f_addr, f_data, f_exp);
					if (code != 4 || (op_tok != "rd" && op_tok != "wr") || n_ops == MAX_OPS) begin
						err_proto = err_proto + 1;
						$display("stim operation %0d on port %s is malformed or too many", n_ops, tok);
					end else begin
						st_port[n_ops] = tok;
						st_wr[n_ops]   = (op_tok == "wr");
						st_addr[n_ops] = f_addr;
						st_data[n_ops] = f_data;
						st_exp[n_ops]  = f_exp;
						n_ops          = n_ops + 1;
					end
				end else begin
					code = $fgets(rest, fd); // a comment runs to the end of its line.
				end
				code = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
			loaded = 1'b1;
		end
	endtask

	// one cycle of random application writes to entries the stim file never uses.
	task automatic fill_unused();
		logic [31:0] rnd;
		rnd     = $random(seed);
		a_wr    = 1'b1;
		a_waddr = {1'b1, rnd[6:0]};
		a_wdata = rnd[31:12];
		b_wr    = 1'b1;
		b_waddr = {1'b1, rnd[11:7]};
		b_wdata = rnd[27:16];
		@(negedge clk);
		a_wr = 1'b0;
		b_wr = 1'b0;
	endtask

	task automatic app_write(input logic [7:0] port, input logic [7:0] idx, input pio_word_t data);
		if (port == "A") begin
			a_wr    = 1'b1;
			a_waddr = tbl_a_addr_t'(idx);
			a_wdata = tbl_a_word_t'(data);
		end else begin
			b_wr    = 1'b1;
			b_waddr = tbl_b_addr_t'(idx);
			b_wdata = tbl_b_word_t'(data);
		end
		@(negedge clk);
		a_wr = 1'b0; // a single cycle strobe.
		b_wr = 1'b0;
	endtask

	// the ack must be seen on the third falling edge after the strobe, and only there.
	task automatic app_read(input logic [7:0] port, input logic [7:0] idx, input pio_word_t exp);
		int   n;
		logic ack;
		if (port == "A") begin
			a_rd    = 1'b1;
			a_raddr = tbl_a_addr_t'(idx);
		end else begin
			b_rd    = 1'b1;
			b_raddr = tbl_b_addr_t'(idx);
		end
		for (n = 1; n <= 4; n++) begin
			@(negedge clk);
			a_rd = 1'b0;
			b_rd = 1'b0;
			ack  = (port == "A") ? a_ack : b_ack;
			if (n != 3 && ack !== 1'b0) begin
				err_proto = err_proto + 1;
				$display("table %s read ack is high %0d cycles after the strobe", port, n);
			end else if (n == 3 && ack !== 1'b1) begin
				err_proto = err_proto + 1;
				$display("table %s read of entry %h got no ack 3 cycles after the strobe", port, idx);
			end else if (n == 3) begin
				if (port == "A") begin
					check_a("a_rdata", a_rdata, tbl_a_word_t'(exp));
				end else begin
					check_b("b_rdata", b_rdata, tbl_b_word_t'(exp));
				end
			end
		end
	endtask

	task automatic pio_start(input pio_word_t addr, input pio_word_t data, input logic is_wr);
		pio_req.addr  = addr;
		pio_req.wdata = data;
		pio_req.rd    = ~is_wr;
		pio_req.wr    = is_wr; // held until the ack is seen.
	endtask

	task automatic pio_finish(input logic is_wr, input pio_word_t exp);
		int n;
		n = 0;
		while (pio_rsp.ack !== 1'b1 && n < ACK_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (pio_rsp.ack !== 1'b1) begin
			err_proto = err_proto + 1;
			$display("host access to %h got no ack within %0d cycles", pio_req.addr, ACK_WAIT);
		end else if (!is_wr) begin
			check_pio("pio_rsp.rdata", pio_rsp.rdata, exp);
		end
		pio_req.rd = 1'b0;
		pio_req.wr = 1'b0;
		n = 0;
		while (pio_rsp.ack !== 1'b0 && n < ACK_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (pio_rsp.ack !== 1'b0) begin
			err_proto = err_proto + 1;
			$display("host ack for %h stayed high after the request was dropped", pio_req.addr);
		end
	endtask

	task automatic run_op(input int i);
		pio_word_t byte_addr;
		byte_addr      = '0;
		byte_addr[9:2] = st_addr[i][7:0]; // collision lines name a table a entry.
		case (st_port[i])
			"A", "B": begin
				if (st_wr[i]) begin
					app_write(st_port[i], st_addr[i][7:0], st_data[i]);
				end else begin
					app_read(st_port[i], st_addr[i][7:0], st_exp[i]);
				end
			end
			"P": begin
				pio_start(st_addr[i], st_data[i], st_wr[i]);
				pio_finish(st_wr[i], st_exp[i]);
			end
			default: begin
				// both ports start in the same cycle, the host write data sits in the expect column.
				if (st_wr[i]) begin
					pio_start(byte_addr, st_exp[i], 1'b1);
					app_write("A", st_addr[i][7:0], st_data[i]);
					pio_finish(1'b1, '0);
				end else begin
					pio_start(byte_addr, '0, 1'b0);
					app_read("A", st_addr[i][7:0], st_exp[i]);
					pio_finish(1'b0, st_exp[i]);
				end
			end
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~ main sequence ~~~~~~~~~~~~~~~~~~~~
	initial begin
		int i;
		seed    = 32'h30a32502;
		rst_n   = 1'b0;
		pio_req = '0;
		a_rd    = 1'b0;
		a_raddr = '0;
		a_wr    = 1'b0;
		a_waddr = '0;
		a_wdata = '0;
		b_rd    = 1'b0;
		b_raddr = '0;
		b_wr    = 1'b0;
		b_waddr = '0;
		b_wdata = '0;
		load_stim();
		repeat (RST_CYCLES) @(negedge clk);
		if (a_ack !== 1'b0 || b_ack !== 1'b0 || pio_rsp.ack !== 1'b0) begin
			err_proto = err_proto + 1;
			$display("an ack is not low at the end of reset");
		end
		rst_n = 1'b1;
		for (i = 0; i < n_ops; i++) begin
			fill_unused();
			run_op(i);
		end
		repeat (4) @(negedge clk);
		$display("%0d operations, %0d value errors, %0d protocol errors", n_ops, err_data, err_proto);
		if (err_data + err_proto == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// the run gets 64 cycles per operation on top of reset.
	initial begin
		int wd_cycles;
		wait (loaded);
		wd_cycles = n_ops * 64 + RST_CYCLES;
		#(wd_cycles * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run is stuck", wd_cycles);
		$display("tests failed");
		$finish;
	end

endmodule

// File: tb/pio_mem_stim.txt
# columns: port op addr wdata expect, all hex. A and B address entries, P uses byte addresses.
# C collides on table a entry addr. rd expects expect on both ports, wr writes wdata then expect.
# application write then read of table a.
A wr 10 00012345 0
A rd 10 0 00012345
A wr 7f 000fffff 0
A rd 7f 0 000fffff
# host access to table a keeps only the low 20 bits.
P wr 00000080 fedcba98 0
P rd 00000080 0 000cba98
A rd 20 0 000cba98
P rd 000001fc 0 000fffff
# table b is read only from the host.
B wr 05 00000abc 0
P wr 00000414 00000123 0
P rd 00000414 0 00000abc
B rd 05 0 00000abc
B wr 1f 00000fff 0
P rd 0000047c 0 00000fff
B rd 1f 0 00000fff
# collisions on table a.
A wr 30 0000beef 0
C rd 30 0 0000beef
C wr 31 00011111 00022222
A rd 31 0 00022222
P rd 000000c4 0 00022222
# unmapped regions ack with zero data.
P rd 00000800 0 0
P wr 00000c00 ffffffff 0
P rd 00000c04 0 0

// File: vlog.f
+incdir+verilog
verilog/pio_mem_pkg.sv
verilog/ram_1r1w.sv
verilog/pio_rw_mem.sv
verilog/pio_resp_merge.sv
verilog/pio_mem_top.sv
tb/pio_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the PIO table testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
	--top-module pio_mem_tb -f vlog.f -Mdir obj_dir -o pio_mem_sim

sim_out="$(./obj_dir/pio_mem_sim)"
echo "${sim_out}"

if grep -qxF "all tests passed" <<< "${sim_out}"; then
	exit 0
fi
echo "simulation did not pass"
exit 1
